//--- rv_core.f
rv_pkg.sv
id_ex_if.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv

//--- run.sh
#!/bin/sh
# Compile and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f rv_core.f \
        --top-module tb_rv_core -o tb_rv_core; then
    echo "Verilator compile failed"
    exit 1
fi

if ! ./obj_dir/tb_rv_core > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "All tests passed!" "$LOG"; then
    exit 0
fi
exit 1

//--- tb_rv_core.sv
`timescale 1ns/1ps
module tb_rv_core import rv_pkg::*; ();

    typedef struct packed {
        logic [31:0] due;
        logic [4:0]  rd;
        logic [31:0] data;
    } exp_t;

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic        insn_valid_i;
    logic [31:0] insn_i;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;

    logic [31:0] model_regs [32];
    exp_t        exp_q [$];
    logic        exp_valid = 1'b0;
    logic [4:0]  exp_rd = '0;
    logic [31:0] exp_data = '0;
    logic [31:0] lfsr = 32'd48;
    int unsigned cyc = 0;
    int unsigned issued = 0;
    int          errors = 0;
    int          errs_at_start = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    string       test_name = "";

    rv_core #(
        .NUM_REGS (32)
    ) rv_core_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .insn_valid_i (insn_valid_i),
        .insn_i       (insn_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    always #4 clk_i = ~clk_i;

    // Expected writeback for this cycle and the watchdog
    always @(posedge clk_i) begin
        cyc = cyc + 1;
        if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            exp_valid <= 1'b1;
            exp_rd    <= exp_q[0].rd;
            exp_data  <= exp_q[0].data;
            void'(exp_q.pop_front());
        end else begin
            exp_valid <= 1'b0;
        end
        if (cyc > 50 * issued + 200) begin
            $display("Timeout: run exceeded %0d cycles in test %s", cyc, test_name);
            $display("Test failures found");
            $finish;
        end
    end

    a_wb_valid: assert property (
        @(posedge clk_i) disable iff (reset_i) wb_valid_o == exp_valid
    ) else begin
        errors++;
        $display("[FAIL] %s: wb_valid_o expected %0b actual %0b", test_name,
                 $sampled(exp_valid), $sampled(wb_valid_o));
    end

    a_wb_rd: assert property (
        @(posedge clk_i) disable iff (reset_i) exp_valid |-> wb_rd_o == exp_rd
    ) else begin
        errors++;
        $display("[FAIL] %s: wb_rd_o expected %0d actual %0d", test_name,
                 $sampled(exp_rd), $sampled(wb_rd_o));
    end

    a_wb_data: assert property (
        @(posedge clk_i) disable iff (reset_i) exp_valid |-> wb_data_o == exp_data
    ) else begin
        errors++;
        $display("[FAIL] %s: wb_data_o for x%0d expected 0x%08h actual 0x%08h", test_name,
                 $sampled(exp_rd), $sampled(exp_data), $sampled(wb_data_o));
    end

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // ISA result at issue time and then one strobe
    task automatic issue(input logic [31:0] insn);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        ok;
        logic        is_imm;
        exp_t        e;
        opc    = insn[6:0];
        rd     = insn[11:7];
        f3     = insn[14:12];
        f7     = insn[31:25];
        is_imm = (opc == OPC_OP_IMM);
        a      = model_regs[insn[19:15]];
        b      = is_imm ? {{20{insn[31]}}, insn[31:20]} : model_regs[insn[24:20]];
        ok     = 1'b0;
        res    = '0;
        if (opc == OPC_LUI) begin
            ok  = 1'b1;
            res = {insn[31:12], 12'h000};
        end else if (opc == OPC_OP || is_imm) begin
            ok = is_imm || f7 == 7'h00;
            case (f3)
                3'd0: begin
                    ok  = is_imm || f7 == 7'h00 || f7 == 7'h20;
                    res = (!is_imm && f7 == 7'h20) ? a - b : a + b;
                end
                3'd1: begin
                    ok  = (f7 == 7'h00);
                    res = a << b[4:0];
                end
                3'd2: res = {31'd0, $signed(a) < $signed(b)};
                3'd3: res = {31'd0, a < b};
                3'd4: res = a ^ b;
                3'd5: begin
                    ok  = (f7 == 7'h00) || (f7 == 7'h20);
                    res = (f7 == 7'h20) ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end
        if (ok && rd != 5'd0) begin
            model_regs[rd] = res;
            e.due  = cyc + 2;
            e.rd   = rd;
            e.data = res;
            exp_q.push_back(e);
        end
        issued++;
        insn_valid_i = 1'b1;
        insn_i       = insn;
        @(posedge clk_i);
        #1;
        insn_valid_i = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errs_at_start = errors;
    endtask

    // Last expected writeback is checked one edge after it leaves the queue
    task automatic end_test();
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);
        #1;
        if (errors == errs_at_start) begin
            tests_ok++;
            $display("%s: ok", test_name);
        end else begin
            tests_bad++;
            $display("%s: %0d check(s) failed", test_name, errors - errs_at_start);
        end
    endtask

    // ADDI r, r, 0 shows every register on the writeback port
    task automatic check_regs();
        for (int r = 1; r < 32; r++) begin
            issue(enc_i(12'h000, 5'(r), 3'd0, 5'(r)));
        end
    endtask

    task automatic run_random(input int n);
        logic [31:0] kind;
        logic [31:0] word;
        logic [31:0] gap;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        for (int k = 0; k < n; k++) begin
            kind = rand_bits(2);
            rd   = 5'(rand_bits(3));
            rs1  = 5'(rand_bits(3));
            rs2  = 5'(rand_bits(3));
            f3   = 3'(rand_bits(3));
            alt  = rand_bits(1) == 32'd1;
            case (kind[1:0])
                2'd0: word = enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
                2'd1: begin
                    imm = 12'(rand_bits(12));
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        imm[11:5] = alt ? 7'h20 : 7'h00;
                    end
                    word = enc_i(imm, rs1, f3, rd);
                end
                2'd2: word = enc_u(20'(rand_bits(20)), rd);
                default: word = rand_bits(32);
            endcase
            issue(word);
            gap = rand_bits(2);
            idle(gap[1] ? int'(gap[0]) + 1 : 0);
        end
    endtask

    initial begin
        reset_i      = 1'b1;
        insn_valid_i = 1'b0;
        insn_i       = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (5) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        begin_test("after_reset");
        idle(10);
        issue(enc_i(12'h000, 5'd7, 3'd0, 5'd5));
        issue(enc_i(12'h000, 5'd31, 3'd0, 5'd12));
        end_test();

        begin_test("alu_ops");
        issue(enc_u(20'h80000, 5'd1));
        issue(enc_i(12'h005, 5'd1, 3'd0, 5'd1));
        issue(enc_u(20'h80000, 5'd2));
        issue(enc_i(12'hff3, 5'd2, 3'd0, 5'd2));
        issue(enc_i(12'h003, 5'd0, 3'd0, 5'd3));
        for (int f = 0; f < 8; f++) begin
            issue(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'(10 + f)));
        end
        issue(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd18));
        issue(enc_r(7'h20, 5'd3, 5'd1, 3'd5, 5'd19));
        issue(enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd20));
        issue(enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd21));
        for (int f = 0; f < 8; f++) begin
            if (f != 1 && f != 5) begin
                issue(enc_i(12'hf81, 5'd1, 3'(f), 5'(22 + f)));
            end
        end
        issue(enc_i({7'h00, 5'd4}, 5'd1, 3'd1, 5'd30));
        issue(enc_i({7'h00, 5'd4}, 5'd1, 3'd5, 5'd31));
        issue(enc_i({7'h20, 5'd4}, 5'd1, 3'd5, 5'd31));
        issue(enc_u(20'hdead5, 5'd9));
        end_test();

        begin_test("forwarding");
        for (int gap = 0; gap < 3; gap++) begin
            issue(enc_i(12'h001, 5'd0, 3'd0, 5'd6));
            idle(gap);
            issue(enc_r(7'h00, 5'd6, 5'd6, 3'd0, 5'd6));
            idle(gap);
            issue(enc_i(12'h7ff, 5'd6, 3'd4, 5'd7));
            idle(gap);
            issue(enc_r(7'h20, 5'd6, 5'd7, 3'd0, 5'd8));
            idle(gap);
            issue(enc_r(7'h00, 5'd8, 5'd6, 3'd1, 5'd6));
            idle(gap);
            issue(enc_r(7'h00, 5'd7, 5'd8, 3'd6, 5'd9));
            idle(gap);
        end
        end_test();

        begin_test("x0_writes");
        issue(enc_i(12'h007, 5'd1, 3'd0, 5'd0));
        issue(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd9));
        issue(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        issue(enc_u(20'h12345, 5'd0));
        issue(enc_i(12'h000, 5'd0, 3'd0, 5'd8));
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));
        end_test();

        begin_test("unsupported");
        issue({12'h004, 5'd1, 3'd2, 5'd11, 7'b0000011});
        issue({7'h00, 5'd2, 5'd1, 3'd2, 5'd4, 7'b0100011});
        issue({7'h00, 5'd2, 5'd1, 3'd0, 5'd8, 7'b1100011});
        issue({20'h00010, 5'd11, 7'b0010111});
        issue(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd11));
        issue(enc_r(7'h20, 5'd2, 5'd1, 3'd1, 5'd11));
        issue(enc_i({7'h20, 5'd3}, 5'd1, 3'd1, 5'd11));
        check_regs();
        end_test();

        begin_test("random_stream");
        run_random(400);
        check_regs();
        end_test();

        $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : tb_rv_core

//--- rv_core.sv
`timescale 1ns/1ps
module rv_core import rv_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  insn_valid_i,
    input  logic [31:0]           insn_i,
    output logic                  wb_valid_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o
);

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    wb_t                   wb;

    id_ex_if idex ();

    rv_decode #(
        .NUM_REGS (NUM_REGS)
    ) decode_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .insn_valid_i (insn_valid_i),
        .insn_i       (insn_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .idex         (idex.decode_mp)
    );

    rv_regfile #(
        .NUM_REGS (NUM_REGS)
    ) regfile_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_execute execute_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .idex    (idex.execute_mp),
        .wb_o    (wb)
    );

    assign wb_valid_o = wb.valid;
    assign wb_rd_o    = wb.rd;
    assign wb_data_o  = wb.data;

endmodule : rv_core

//--- rv_execute.sv
`timescale 1ns/1ps
module rv_execute import rv_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    id_ex_if.execute_mp idex,
    output wb_t         wb_o
);

    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2_reg;
    logic [XLEN-1:0] op2;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_res;

    // Result of the previous instruction is still in the writeback register
    assign fwd_rs1 = wb_o.valid && (wb_o.rd == idex.rs1);
    assign fwd_rs2 = wb_o.valid && (wb_o.rd == idex.rs2);

    assign op1     = fwd_rs1 ? wb_o.data : idex.rs1_data;
    assign op2_reg = fwd_rs2 ? wb_o.data : idex.rs2_data;
    assign op2     = idex.op2_is_imm ? idex.imm : op2_reg;
    assign shamt   = op2[4:0];

    always_comb begin
        case (idex.alu_op)
            ALU_ADD: begin
                alu_res = op1 + op2;
            end
            ALU_SUB: begin
                alu_res = op1 - op2;
            end
            ALU_SLL: begin
                alu_res = op1 << shamt;
            end
            ALU_SLT: begin
                alu_res = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            end
            ALU_SLTU: begin
                alu_res = {{(XLEN-1){1'b0}}, op1 < op2};
            end
            ALU_XOR: begin
                alu_res = op1 ^ op2;
            end
            ALU_SRL: begin
                alu_res = op1 >> shamt;
            end
            ALU_SRA: begin
                alu_res = $unsigned($signed(op1) >>> shamt);
            end
            ALU_OR: begin
                alu_res = op1 | op2;
            end
            ALU_AND: begin
                alu_res = op1 & op2;
            end
            default: begin
                // LUI
                alu_res = op2;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_o.valid <= 1'b0;
        end else begin
            wb_o.valid <= idex.valid && (idex.rd != '0);
        end
    end

    always_ff @(posedge clk_i) begin
        wb_o.rd   <= idex.rd;
        wb_o.data <= alu_res;
    end

    a_wb_valid_rd: assert property (
        @(posedge clk_i) disable iff (reset_i)
        wb_o.valid |-> wb_o.rd != '0
    );

endmodule : rv_execute

//--- rv_regfile.sv
`timescale 1ns/1ps
module rv_regfile import rv_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  wb_t                   wb_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    // x0 has no storage
    logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.rd != '0) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    // Write in the same cycle wins over stored value
    function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] data;
        data = '0;
        if (addr != '0 && int'(addr) < NUM_REGS) begin
            if (wb_i.valid && wb_i.rd == addr) begin
                data = wb_i.data;
            end else begin
                data = regs_q[addr];
            end
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_reg(rs1_addr_i);
    end

    always_comb begin
        rs2_data_o = read_reg(rs2_addr_i);
    end

    a_no_x0_write: assert property (
        @(posedge clk_i) disable iff (reset_i)
        wb_i.valid |-> wb_i.rd != '0 && int'(wb_i.rd) < NUM_REGS
    );

endmodule : rv_regfile

//--- rv_decode.sv
`timescale 1ns/1ps
module rv_decode import rv_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  insn_valid_i,
    input  logic [31:0]           insn_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    id_ex_if.decode_mp            idex
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;

    alu_op_e               base_op;
    alu_op_e               alu_op;
    logic                  supported;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  op2_is_imm;
    logic [XLEN-1:0]       imm;
    logic                  regs_ok;

    assign opcode = insn_i[6:0];
    assign rd     = insn_i[11:7];
    assign funct3 = insn_i[14:12];
    assign rs1    = insn_i[19:15];
    assign rs2    = insn_i[24:20];
    assign funct7 = insn_i[31:25];

    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    function automatic logic in_range(input logic [REG_ADDR_W-1:0] idx);
        return int'(idx) < NUM_REGS;
    endfunction

    // Same funct3 mapping for register and immediate forms
    always_comb begin
        case (funct3)
            F3_ADD_SUB: base_op = ALU_ADD;
            F3_SLL:     base_op = ALU_SLL;
            F3_SLT:     base_op = ALU_SLT;
            F3_SLTU:    base_op = ALU_SLTU;
            F3_XOR:     base_op = ALU_XOR;
            F3_SRL_SRA: base_op = ALU_SRL;
            F3_OR:      base_op = ALU_OR;
            default:    base_op = ALU_AND;
        endcase
    end

    always_comb begin
        alu_op     = base_op;
        supported  = 1'b0;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        op2_is_imm = 1'b0;
        imm        = {{20{insn_i[31]}}, insn_i[31:20]};
        case (opcode)
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct7 == FUNCT7_NORM) begin
                    supported = 1'b1;
                end else if (funct7 == FUNCT7_ALT) begin
                    if (funct3 == F3_ADD_SUB) begin
                        supported = 1'b1;
                        alu_op    = ALU_SUB;
                    end else if (funct3 == F3_SRL_SRA) begin
                        supported = 1'b1;
                        alu_op    = ALU_SRA;
                    end
                end
            end
            OPC_OP_IMM: begin
                use_rs1    = 1'b1;
                op2_is_imm = 1'b1;
                if (funct3 == F3_SLL) begin
                    supported = (funct7 == FUNCT7_NORM);
                end else if (funct3 == F3_SRL_SRA) begin
                    // SRAI is the only immediate op with the alternate funct7
                    supported = (funct7 == FUNCT7_NORM) || (funct7 == FUNCT7_ALT);
                    if (funct7 == FUNCT7_ALT) begin
                        alu_op = ALU_SRA;
                    end
                end else begin
                    supported = 1'b1;
                end
            end
            OPC_LUI: begin
                supported  = 1'b1;
                op2_is_imm = 1'b1;
                alu_op     = ALU_PASS_B;
                imm        = {insn_i[31:12], 12'b0};
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // Indices past the implemented registers make the instruction a no-op
    assign regs_ok = in_range(rd) && (!use_rs1 || in_range(rs1)) && (!use_rs2 || in_range(rs2));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            idex.valid <= 1'b0;
        end else begin
            idex.valid <= insn_valid_i && supported && regs_ok;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk_i) begin
        idex.alu_op     <= alu_op;
        idex.rd         <= rd;
        idex.rs1        <= rs1;
        idex.rs2        <= rs2;
        idex.rs1_data   <= rs1_data_i;
        idex.rs2_data   <= rs2_data_i;
        idex.imm        <= imm;
        idex.op2_is_imm <= op2_is_imm;
    end

    a_no_sub_imm: assert property (
        @(posedge clk_i) disable iff (reset_i)
        idex.valid && idex.op2_is_imm && (idex.alu_op inside {ALU_SUB, ALU_SRA})
        |-> idex.alu_op == ALU_SRA && idex.imm[11:5] == FUNCT7_ALT
    );

endmodule : rv_decode

//--- id_ex_if.sv
`timescale 1ns/1ps
interface id_ex_if import rv_pkg::*; ();

    logic                  valid;
    alu_op_e               alu_op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm;
    logic                  op2_is_imm;

    modport decode_mp (
        output valid, alu_op, rd, rs1, rs2, rs1_data, rs2_data, imm, op2_is_imm
    );

    modport execute_mp (
        input  valid, alu_op, rd, rs1, rs2, rs1_data, rs2_data, imm, op2_is_imm
    );

endinterface : id_ex_if

//--- rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes accepted by the core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 is shared by the register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Alternate form selects SUB and SRA/SRAI
    localparam logic [6:0] FUNCT7_NORM = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // One register file write, 38 bits
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage : rv_pkg
